/* Bender.yml */
package:
  name: booth_mul

sources:
  - hw/booth_mul_pkg.sv
  - hw/booth_datapath.sv
  - hw/booth_control.sv
  - hw/booth_apb_regs.sv
  - hw/booth_mul_top.sv
  - target: simulation
    files:
      - sim/booth_clk_gen.sv
      - sim/booth_mul_tb.sv

/* booth_mul.f */
hw/booth_mul_pkg.sv
hw/booth_datapath.sv
hw/booth_control.sv
hw/booth_apb_regs.sv
hw/booth_mul_top.sv
sim/booth_clk_gen.sv
sim/booth_mul_tb.sv

/* hw/booth_apb_regs.sv */
module booth_apb_regs (
    input  logic                                 clk,
    input  logic                                 rst,
    input  booth_mul_pkg::apb_req_t              req,
    output booth_mul_pkg::apb_rsp_t              rsp,
    input  logic                                 busy,
    input  logic                                 done,
    input  logic [booth_mul_pkg::prod_width-1:0] product,
    output booth_mul_pkg::mul_operands_t         operands,
    output logic                                 start
);

    logic access;
    logic wr;
    logic rd;
    logic addr_hit;
    logic done_d;
    logic capture;

    logic [booth_mul_pkg::prod_width-1:0] product_q;
    logic [31:0]                          rdata;

    // Access phase, always completed in this cycle
    assign access = req.psel && req.penable;
    assign wr     = access && req.pwrite;
    assign rd     = access && !req.pwrite;

    always_comb begin
        case (req.paddr)
            booth_mul_pkg::addr_ctrl,
            booth_mul_pkg::addr_status,
            booth_mul_pkg::addr_operands,
            booth_mul_pkg::addr_product: addr_hit = 1'b1;
            default:                     addr_hit = 1'b0;
        endcase
    end

    // Start request is dropped while a product is being computed
    assign start = wr && (req.paddr == booth_mul_pkg::addr_ctrl) && req.pwdata[0] && !busy;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            operands <= '0;
        end else if (wr && (req.paddr == booth_mul_pkg::addr_operands)) begin
            operands <= req.pwdata;
        end
    end

    // Grab the result once, on the first cycle done is seen high
    assign capture = done && !done_d;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            done_d <= 1'b0;
        end else begin
            done_d <= done;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            product_q <= '0;
        end else if (capture) begin
            product_q <= product;
        end
    end

    // Read mux
    always_comb begin
        rdata = '0;
        if (rd) begin
            case (req.paddr)
                booth_mul_pkg::addr_status: begin
                    rdata = {30'b0, done, busy};
                end
                booth_mul_pkg::addr_operands: begin
                    rdata = operands;
                end
                booth_mul_pkg::addr_product: begin
                    rdata = product_q;
                end
                default: begin
                    // control reads back as zero, start bit self-clears
                    rdata = '0;
                end
            endcase
        end
    end

    assign rsp.prdata  = rdata;
    assign rsp.pready  = 1'b1;
    assign rsp.pslverr = access && !addr_hit;

endmodule

/* hw/booth_control.sv */
module booth_control (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  booth_mul_pkg::dp_stat_t  stat,
    output booth_mul_pkg::dp_cmd_t   cmd,
    output logic                     busy,
    output logic                     done
);

    typedef enum logic [1:0] {
        s_idle   = 2'b00,
        s_load   = 2'b01,
        s_run    = 2'b10,
        s_finish = 2'b11
    } state_e;

    state_e state;
    state_e state_next;
    booth_mul_pkg::booth_op_e step_op;

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            s_idle: begin
                if (start) begin
                    state_next = s_load;
                end
            end
            s_load: begin
                state_next = s_run;
            end
            s_run: begin
                if (stat.last_step) begin
                    state_next = s_finish;
                end
            end
            s_finish: begin
                // Result held here until another start comes in
                if (start) begin
                    state_next = s_load;
                end
            end
            default: begin
                state_next = s_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= s_idle;
        end else begin
            state <= state_next;
        end
    end

    // Booth recoding of {q0, q-1}
    always_comb begin
        case (stat.booth_pair)
            2'b10:   step_op = booth_mul_pkg::op_sub;
            2'b01:   step_op = booth_mul_pkg::op_add;
            default: step_op = booth_mul_pkg::op_pass;
        endcase
    end

    assign cmd.load = (state == s_load);
    assign cmd.step = (state == s_run);
    assign cmd.op   = (state == s_run) ? step_op : booth_mul_pkg::op_pass;

    assign busy = (state == s_load) || (state == s_run);
    assign done = (state == s_finish);

endmodule

/* hw/booth_datapath.sv */
module booth_datapath (
    input  logic                                 clk,
    input  logic                                 rst,
    input  booth_mul_pkg::mul_operands_t         operands,
    input  booth_mul_pkg::dp_cmd_t               cmd,
    output booth_mul_pkg::dp_stat_t              stat,
    output logic [booth_mul_pkg::prod_width-1:0] product
);

    localparam int unsigned w = booth_mul_pkg::data_width;
    localparam int unsigned cnt_width = $clog2(booth_mul_pkg::steps) + 1;

    // Working registers of the multiplier
    logic [w-1:0]         mcand;
    logic [w-1:0]         acc;
    logic [w-1:0]         mplier;
    logic                 prev_bit;
    logic [cnt_width-1:0] count;

    // One extra bit so that subtracting -2^(w-1) cannot overflow
    logic [w:0] acc_ext;
    logic [w:0] mcand_ext;
    logic [w:0] sum;

    assign acc_ext   = {acc[w-1], acc};
    assign mcand_ext = {mcand[w-1], mcand};

    always_comb begin
        case (cmd.op)
            booth_mul_pkg::op_add: begin
                sum = acc_ext + mcand_ext;
            end
            booth_mul_pkg::op_sub: begin
                sum = acc_ext - mcand_ext;
            end
            default: begin
                sum = acc_ext;
            end
        endcase
    end

    // Add/subtract then arithmetic shift of {acc, mplier, prev_bit}
    always_ff @(posedge clk) begin
        if (cmd.load) begin
            mcand    <= operands.multiplicand;
            mplier   <= operands.multiplier;
            acc      <= '0;
            prev_bit <= 1'b0;
        end else if (cmd.step) begin
            acc      <= sum[w:1];
            mplier   <= {sum[0], mplier[w-1:1]};
            prev_bit <= mplier[0];
        end
    end

    // Step counter
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count <= '0;
        end else if (cmd.load) begin
            count <= '0;
        end else if (cmd.step) begin
            count <= count + 1'b1;
        end
    end

    assign stat.booth_pair = {mplier[0], prev_bit};
    // High while the final iteration is being applied
    assign stat.last_step  = (count == cnt_width'(booth_mul_pkg::steps - 1));

    assign product = {acc, mplier};

endmodule

/* hw/booth_mul_pkg.sv */
package booth_mul_pkg;

    // Operand and product sizes
    localparam int unsigned data_width = 16;
    localparam int unsigned prod_width = 2 * data_width;

    // One Booth iteration per multiplier bit
    localparam int unsigned steps = data_width;

    // APB register offsets
    localparam logic [7:0] addr_ctrl     = 8'h00;
    localparam logic [7:0] addr_status   = 8'h04;
    localparam logic [7:0] addr_operands = 8'h08;
    localparam logic [7:0] addr_product  = 8'h0C;

    // Accumulator operation for one step
    typedef enum logic [1:0] {
        op_pass = 2'b00,
        op_add  = 2'b01,
        op_sub  = 2'b10
    } booth_op_e;

    typedef struct packed {
        logic      load;
        logic      step;
        booth_op_e op;
    } dp_cmd_t;

    // booth_pair is {multiplier bit 0, previous bit}
    typedef struct packed {
        logic [1:0] booth_pair;
        logic       last_step;
    } dp_stat_t;

    typedef struct packed {
        logic [data_width-1:0] multiplier;
        logic [data_width-1:0] multiplicand;
    } mul_operands_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

/* hw/booth_mul_top.sv */
module booth_mul_top (
    input  logic                     clk,
    input  logic                     rst,
    input  booth_mul_pkg::apb_req_t  apb_req,
    output booth_mul_pkg::apb_rsp_t  apb_rsp
);

    // Register block to controller and datapath
    logic                          start;
    booth_mul_pkg::mul_operands_t  operands;

    // Controller and datapath handshake
    booth_mul_pkg::dp_cmd_t        dp_cmd;
    booth_mul_pkg::dp_stat_t       dp_stat;
    logic                          busy;
    logic                          done;

    logic [booth_mul_pkg::prod_width-1:0] product;

    booth_apb_regs u_apb_regs (
        .clk      (clk),
        .rst      (rst),
        .req      (apb_req),
        .rsp      (apb_rsp),
        .busy     (busy),
        .done     (done),
        .product  (product),
        .operands (operands),
        .start    (start)
    );

    booth_control u_control (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .stat  (dp_stat),
        .cmd   (dp_cmd),
        .busy  (busy),
        .done  (done)
    );

    booth_datapath u_datapath (
        .clk      (clk),
        .rst      (rst),
        .operands (operands),
        .cmd      (dp_cmd),
        .stat     (dp_stat),
        .product  (product)
    );

endmodule

/* sim/booth_clk_gen.sv */
module booth_clk_gen #(
    parameter int unsigned period = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Free-running clock, low for the first half period
    always begin
        #(period / 2);
        clk = ~clk;
    end

endmodule

/* sim/booth_mul_tb.sv */
module booth_mul_tb;

    localparam int unsigned clk_period    = 40;
    localparam int unsigned done_timeout  = 100;
    localparam int unsigned drain_timeout = 10;
    localparam int unsigned random_pairs  = 64;

    // One product read back from the DUT with the operands that made it
    typedef struct packed {
        booth_mul_pkg::mul_operands_t         operands;
        logic [booth_mul_pkg::prod_width-1:0] product;
    } result_t;

    logic                    clk;
    logic                    rst;
    booth_mul_pkg::apb_req_t apb_req;
    booth_mul_pkg::apb_rsp_t apb_rsp;

    logic [31:0]     lfsr_state;
    longint unsigned cycle_count;
    result_t         result_q[$];
    result_t         result_entry;
    int unsigned     pushed_count;
    int unsigned     checked_count;

    booth_clk_gen #(.period(clk_period)) u_clk_gen (.clk(clk));

    booth_mul_top u_booth_mul_top (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic draw_bits(input int unsigned count, output logic [31:0] value);
        value = '0;
        for (int unsigned i = 0; i < count; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // Expected signed product from plain wide multiplication
    function automatic logic [31:0] ref_product(input logic signed [15:0] mcand,
                                                input logic signed [15:0] mplier);
        logic signed [31:0] wide_mcand;
        logic signed [31:0] wide_mplier;
        wide_mcand  = mcand;
        wide_mplier = mplier;
        return wide_mcand * wide_mplier;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at time %0t: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    task automatic report_stall(input string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Stopped on a timeout");
    endtask

    task automatic check_product(input logic [booth_mul_pkg::prod_width-1:0] actual,
                                 input logic [booth_mul_pkg::prod_width-1:0] expected,
                                 input string what);
        if (actual !== expected) begin
            report_mismatch($sformatf("%s: got 0x%08h, expected 0x%08h", what, actual, expected));
        end
    endtask

    task automatic check_status(input logic busy, input logic done,
                                input logic exp_busy, input logic exp_done, input string what);
        if (busy !== exp_busy || done !== exp_done) begin
            report_mismatch($sformatf("%s: busy %b done %b, expected busy %b done %b",
                                      what, busy, done, exp_busy, exp_done));
        end
    endtask

    task automatic check_rsp(input booth_mul_pkg::apb_rsp_t actual, input logic exp_err,
                             input logic [31:0] exp_data, input string what);
        if (actual.pslverr !== exp_err || actual.prdata !== exp_data) begin
            report_mismatch($sformatf("%s: pslverr %b prdata 0x%08h, expected %b 0x%08h",
                                      what, actual.pslverr, actual.prdata, exp_err, exp_data));
        end
    endtask

    // Zero wait states, so pready must be high in the first access cycle
    task automatic check_ready(input booth_mul_pkg::apb_rsp_t actual, input string what);
        if (actual.pready !== 1'b1) begin
            report_mismatch($sformatf("%s: pready %b, expected 1", what, actual.pready));
        end
    endtask

    // Setup phase and one access phase, response taken at the closing edge
    task automatic apb_access(input logic write, input logic [7:0] addr, input logic [31:0] data,
                              output booth_mul_pkg::apb_rsp_t rsp);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(negedge clk);
        apb_req.penable = 1'b1;
        @(posedge clk);
        rsp = apb_rsp;
        check_ready(rsp, $sformatf("access at 0x%02h", addr));
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output booth_mul_pkg::apb_rsp_t rsp);
        apb_access(1'b1, addr, data, rsp);
    endtask

    task automatic apb_read(input logic [7:0] addr, output booth_mul_pkg::apb_rsp_t rsp);
        apb_access(1'b0, addr, 32'h0, rsp);
    endtask

    task automatic write_operands(input logic [15:0] mcand, input logic [15:0] mplier);
        booth_mul_pkg::apb_rsp_t rsp;
        apb_write(booth_mul_pkg::addr_operands, {mplier, mcand}, rsp);
        check_rsp(rsp, 1'b0, 32'h0, "operand write");
    endtask

    task automatic start_mul();
        booth_mul_pkg::apb_rsp_t rsp;
        apb_write(booth_mul_pkg::addr_ctrl, 32'h1, rsp);
        check_rsp(rsp, 1'b0, 32'h0, "start write");
    endtask

    // Busy must stay high on every status read until done shows up
    task automatic wait_done();
        booth_mul_pkg::apb_rsp_t rsp;
        longint unsigned         first_cycle;
        logic                    finished;
        first_cycle = cycle_count;
        finished    = 1'b0;
        while (!finished) begin
            apb_read(booth_mul_pkg::addr_status, rsp);
            finished = rsp.prdata[1];
            if (finished) begin
                check_status(rsp.prdata[0], rsp.prdata[1], 1'b0, 1'b1, "status at done");
            end else begin
                check_status(rsp.prdata[0], rsp.prdata[1], 1'b1, 1'b0, "status while running");
                if (cycle_count - first_cycle > done_timeout) begin
                    report_stall("the multiplier never finished within 100 cycles");
                end
            end
        end
    endtask

    // Product goes to the compare process together with its operands
    task automatic read_product(input logic [15:0] mcand, input logic [15:0] mplier);
        booth_mul_pkg::apb_rsp_t rsp;
        result_t                 entry;
        apb_read(booth_mul_pkg::addr_product, rsp);
        entry.operands.multiplicand = mcand;
        entry.operands.multiplier   = mplier;
        entry.product               = rsp.prdata;
        result_q.push_back(entry);
        pushed_count++;
    endtask

    task automatic run_product(input logic [15:0] mcand, input logic [15:0] mplier);
        write_operands(mcand, mplier);
        start_mul();
        wait_done();
        read_product(mcand, mplier);
    endtask

    // Compare process
    always @(negedge clk) begin
        if (result_q.size() > 0) begin
            result_entry = result_q.pop_front();
            check_product(result_entry.product,
                          ref_product(result_entry.operands.multiplicand,
                                      result_entry.operands.multiplier),
                          $sformatf("product of %0d and %0d",
                                    $signed(result_entry.operands.multiplicand),
                                    $signed(result_entry.operands.multiplier)));
            checked_count = checked_count + 1;
        end
    end

    initial begin
        booth_mul_pkg::apb_rsp_t rsp;
        logic [31:0]             rand_a;
        logic [31:0]             rand_b;
        int unsigned             waited;
        apb_req       = '0;
        rst           = 1'b0;
        lfsr_state    = 32'h597e;
        cycle_count   = 0;
        pushed_count  = 0;
        checked_count = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        // Reset values
        apb_read(booth_mul_pkg::addr_status, rsp);
        check_status(rsp.prdata[0], rsp.prdata[1], 1'b0, 1'b0, "status after reset");
        apb_read(booth_mul_pkg::addr_operands, rsp);
        check_rsp(rsp, 1'b0, 32'h0, "operands after reset");
        apb_read(booth_mul_pkg::addr_product, rsp);
        check_product(rsp.prdata, 32'h0, "product after reset");

        // Corner operands
        run_product(16'h0000, 16'h3039);
        run_product(16'h5a5a, 16'h0000);
        run_product(16'h0001, 16'hffff);
        run_product(16'h8000, 16'h8000);
        run_product(16'h7fff, 16'h8000);
        run_product(16'hffff, 16'hffff);

        for (int unsigned i = 0; i < random_pairs; i++) begin
            draw_bits(16, rand_a);
            draw_bits(16, rand_b);
            run_product(rand_a[15:0], rand_b[15:0]);
        end

        // A second start with new operands while busy is dropped
        write_operands(16'h1b7e, 16'hd431);
        start_mul();
        write_operands(16'hfedc, 16'h0123);
        start_mul();
        wait_done();
        read_product(16'h1b7e, 16'hd431);
        apb_read(booth_mul_pkg::addr_operands, rsp);
        check_rsp(rsp, 1'b0, {16'h0123, 16'hfedc}, "operands written while busy");
        start_mul();
        wait_done();
        read_product(16'hfedc, 16'h0123);

        // Unmapped offsets and the read-only product register
        apb_read(8'h10, rsp);
        check_rsp(rsp, 1'b1, 32'h0, "read at 0x10");
        apb_read(8'h02, rsp);
        check_rsp(rsp, 1'b1, 32'h0, "read at 0x02");
        apb_write(8'hf0, 32'hdead_beef, rsp);
        check_rsp(rsp, 1'b1, 32'h0, "write at 0xf0");
        apb_read(booth_mul_pkg::addr_operands, rsp);
        check_rsp(rsp, 1'b0, {16'h0123, 16'hfedc}, "operands after unmapped write");
        apb_write(booth_mul_pkg::addr_product, 32'h1234_5678, rsp);
        check_rsp(rsp, 1'b0, 32'h0, "write to product register");
        apb_read(booth_mul_pkg::addr_product, rsp);
        check_product(rsp.prdata, ref_product(16'hfedc, 16'h0123), "product after write");

        // Restart after a result keeps the old product until the new done
        write_operands(16'hc3a5, 16'h4001);
        start_mul();
        apb_read(booth_mul_pkg::addr_status, rsp);
        check_status(rsp.prdata[0], rsp.prdata[1], 1'b1, 1'b0, "status after restart");
        read_product(16'hfedc, 16'h0123);
        wait_done();
        read_product(16'hc3a5, 16'h4001);

        waited = 0;
        while (checked_count != pushed_count) begin
            @(posedge clk);
            waited++;
            if (waited > drain_timeout) begin
                report_stall("the compare process did not see every product");
            end
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
